// File: logic/clmul_consts.svh
/* Carry-less multiplier constants */

`ifndef CLMUL_CONSTS_SVH
`define CLMUL_CONSTS_SVH

// Operand width in bits
`define CLMUL_OPND_W 8

// Number of multiply lanes
`define CLMUL_LANES 4

// Word addresses on the bus
`define CLMUL_ADDR_OPND 2'd0
`define CLMUL_ADDR_RSLT 2'd1

`endif

// File: logic/clmul_pkg.sv
/* Carry-less multiplier types */

`default_nettype none

`include "clmul_consts.svh"

package clmul_pkg;

    typedef logic [`CLMUL_OPND_W-1:0] opnd_t;

    // Top bit of a carry-less product never sets
    typedef logic [2*`CLMUL_OPND_W-1:0] prod_t;

    // At least one bit, also for a single lane
    typedef logic [($clog2(`CLMUL_LANES) > 0 ? $clog2(`CLMUL_LANES) : 1)-1:0] lane_idx_t;

    typedef logic [31:0] wb_data_t;

    // Operand a in the low byte, b above it
    typedef struct packed {
        opnd_t b;
        opnd_t a;
    } clmul_req_t;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } lane_state_t;

endpackage

`default_nettype wire

// File: logic/clmul_lane.sv
/* Carry-less multiply lane */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_lane
    import clmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  clmul_req_t req,
    input  logic       take,
    output logic       lane_ready,
    output logic       rslt_valid,
    output prod_t      rslt
);

    lane_state_t state;
    clmul_req_t  opnd_q;
    prod_t       prod_c;

    // Handshake FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    state <= DONE;
                end
                DONE: begin
                    // Released only when the collector takes it
                    if (take) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            opnd_q <= req;
        end
    end

    // Partial products combined with xor, no carries
    always_comb begin
        prod_c = '0;
        for (int i = 0; i < `CLMUL_OPND_W; i++) begin
            if (opnd_q.a[i]) begin
                prod_c = prod_c ^ (prod_t'(opnd_q.b) << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == CALC) begin
            rslt <= prod_c;
        end
    end

    assign lane_ready = (state == IDLE);
    assign rslt_valid = (state == DONE);

endmodule

`default_nettype wire

// File: logic/clmul_dispatch.sv
/* Round-robin operand dispatcher */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_dispatch
    import clmul_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  clmul_req_t              req,
    output logic                    req_ready,
    input  logic [`CLMUL_LANES-1:0] lane_ready,
    output logic [`CLMUL_LANES-1:0] start,
    output clmul_req_t              lane_req
);

    lane_idx_t ptr;
    logic      fire;

    // Only the lane under the pointer may accept
    assign req_ready = lane_ready[ptr];
    assign fire      = req_valid && req_ready;

    always_comb begin
        start = '0;
        if (fire) begin
            start[ptr] = 1'b1;
        end
    end

    // All lanes share the operand bus, start selects one
    assign lane_req = req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (fire) begin
            if (ptr == lane_idx_t'(`CLMUL_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/clmul_collect.sv
/* In-order result collector */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_collect
    import clmul_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CLMUL_LANES-1:0] rslt_valid,
    input  prod_t                   rslt [`CLMUL_LANES],
    output logic [`CLMUL_LANES-1:0] take,
    input  logic                    pop,
    output logic                    out_valid,
    output prod_t                   out
);

    lane_idx_t ptr;
    logic      slot_valid;
    prod_t     slot;
    logic      take_fire;

    // Pointer walks the lanes in issue order
    assign take_fire = rslt_valid[ptr] && !slot_valid;

    always_comb begin
        take = '0;
        if (take_fire) begin
            take[ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (take_fire) begin
            if (ptr == lane_idx_t'(`CLMUL_LANES - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // One-entry output slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else if (take_fire) begin
            slot_valid <= 1'b1;
        end else if (pop) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_fire) begin
            slot <= rslt[ptr];
        end
    end

    assign out_valid = slot_valid;
    assign out       = slot;

endmodule

`default_nettype wire

// File: logic/clmul_wb_slave.sv
/* Wishbone classic register slave */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_wb_slave
    import clmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  wb_data_t   dat_w,
    output logic       ack,
    output wb_data_t   dat_r,
    output logic       req_valid,
    output clmul_req_t req,
    input  logic       req_ready,
    output logic       pop,
    input  logic       out_valid,
    input  prod_t      out
);

    logic bus_req;
    logic is_opnd;
    logic is_rslt;
    logic accept;
    logic rd_rslt;

    // A cycle in progress that has not been acked yet
    assign bus_req = cyc && stb && !ack;
    assign is_opnd = (adr == `CLMUL_ADDR_OPND);
    assign is_rslt = (adr == `CLMUL_ADDR_RSLT);

    // Operand write stays pending while the dispatcher is busy
    assign req_valid = bus_req && we && is_opnd;
    assign req       = clmul_req_t'(dat_w[2*`CLMUL_OPND_W-1:0]);

    assign accept  = bus_req && (!req_valid || req_ready);
    assign rd_rslt = accept && !we && is_rslt && out_valid;

    // Reading a held result removes it
    assign pop = rd_rslt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // Valid flag sits just above the product
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dat_r <= '0;
        end else if (rd_rslt) begin
            dat_r <= wb_data_t'({1'b1, out});
        end else begin
            dat_r <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/clmul_top.sv
/* Carry-less multiply accelerator */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_top
    import clmul_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  wb_data_t   dat_w,
    output logic       ack,
    output wb_data_t   dat_r
);

    logic                    req_valid;
    logic                    req_ready;
    clmul_req_t              req;
    clmul_req_t              lane_req;
    logic [`CLMUL_LANES-1:0] lane_ready;
    logic [`CLMUL_LANES-1:0] start;
    logic [`CLMUL_LANES-1:0] rslt_valid;
    logic [`CLMUL_LANES-1:0] take;
    prod_t                   rslt [`CLMUL_LANES];
    logic                    pop;
    logic                    out_valid;
    prod_t                   out;

    clmul_wb_slave u_wb_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .ack       (ack),
        .dat_r     (dat_r),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .pop       (pop),
        .out_valid (out_valid),
        .out       (out)
    );

    clmul_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .lane_ready (lane_ready),
        .start      (start),
        .lane_req   (lane_req)
    );

    for (genvar i = 0; i < `CLMUL_LANES; i++) begin : g_lane
        clmul_lane u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .start      (start[i]),
            .req        (lane_req),
            .take       (take[i]),
            .lane_ready (lane_ready[i]),
            .rslt_valid (rslt_valid[i]),
            .rslt       (rslt[i])
        );
    end

    clmul_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .rslt_valid (rslt_valid),
        .rslt       (rslt),
        .take       (take),
        .pop        (pop),
        .out_valid  (out_valid),
        .out        (out)
    );

endmodule

`default_nettype wire

// File: dv/clmul_chk.sv
/* Bus and lane handshake checks */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    cyc,
    input logic                    stb,
    input logic                    ack,
    input logic [`CLMUL_LANES-1:0] start,
    input logic [`CLMUL_LANES-1:0] take,
    input logic [`CLMUL_LANES-1:0] rslt_valid
);

    // Classic single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack held for more than one cycle");

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else $error("ack without a preceding cyc and stb");

    start_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(start))
        else $error("more than one lane started at once");

    // A lane gives up its result only when it holds one
    take_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (take & ~rslt_valid) == '0)
        else $error("take sent to a lane without a valid result");

endmodule

bind clmul_top clmul_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc        (cyc),
    .stb        (stb),
    .ack        (ack),
    .start      (start),
    .take       (take),
    .rslt_valid (rslt_valid)
);

`default_nettype wire

// File: dv/clmul_tb.sv
/* Carry-less multiplier testbench */

`timescale 1ns/100ps
`default_nettype none

`include "clmul_consts.svh"

module clmul_tb
    import clmul_pkg::*;
();

    localparam int ACK_WAIT   = 50;
    localparam int BLOCK_WAIT = 20;
    localparam int POLL_MAX   = 20;

    // Addresses outside the register map
    localparam logic [1:0] ADDR_UNMAPPED_W = 2'd2;
    localparam logic [1:0] ADDR_UNMAPPED_R = 2'd3;

    logic       clk;
    logic       rst_n;
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    wb_data_t   dat_w;
    logic       ack;
    wb_data_t   dat_r;

    int checks;
    int errors;
    int timeouts;

    clmul_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .ack   (ack),
        .dat_r (dat_r)
    );

    always #2 clk = ~clk;

    // Each bit pair lands on the sum of its positions
    function automatic prod_t clmul_ref(input opnd_t a, input opnd_t b);
        prod_t p;
        p = '0;
        for (int i = 0; i < `CLMUL_OPND_W; i++) begin
            for (int j = 0; j < `CLMUL_OPND_W; j++) begin
                p[i+j] = p[i+j] ^ (a[i] & b[j]);
            end
        end
        return p;
    endfunction

    task automatic check_eq(input string what, input wb_data_t got, input wb_data_t exp);
        checks++;
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One classic cycle, abandoned after max_wait cycles without ack
    task automatic bus_access(input logic wr, input logic [1:0] addr, input wb_data_t wdata,
                              input int max_wait, output logic acked, output wb_data_t rdata);
        int n;
        acked = 1'b0;
        rdata = '0;
        n = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = addr;
        dat_w = wdata;
        while (!acked && n < max_wait) begin
            @(negedge clk);
            n++;
            if (ack) begin
                acked = 1'b1;
                rdata = dat_r;
            end
        end
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        dat_w = '0;
    endtask

    task automatic write_op(input logic [1:0] addr, input opnd_t a, input opnd_t b);
        logic     acked;
        wb_data_t rd;
        bus_access(1'b1, addr, wb_data_t'({b, a}), ACK_WAIT, acked, rd);
        if (!acked) begin
            $display("Write to address %0d was never acknowledged (time %0t ns)", addr, $time);
            timeouts++;
        end
    endtask

    // All lanes and the slot are full, so no ack may come
    task automatic write_stalled(input opnd_t a, input opnd_t b);
        logic     acked;
        wb_data_t rd;
        bus_access(1'b1, `CLMUL_ADDR_OPND, wb_data_t'({b, a}), BLOCK_WAIT, acked, rd);
        checks++;
        assert (!acked) else begin
            $display("CHECK FAILED at %0t ns: write of a=%h b=%h acked while full",
                     $time, a, b);
            errors++;
        end
    endtask

    task automatic read_reg(input logic [1:0] addr, output wb_data_t rd);
        logic acked;
        bus_access(1'b0, addr, '0, ACK_WAIT, acked, rd);
        if (!acked) begin
            $display("Read of address %0d was never acknowledged (time %0t ns)", addr, $time);
            timeouts++;
        end
    endtask

    task automatic read_expect_zero(input logic [1:0] addr, input string what);
        wb_data_t rd;
        read_reg(addr, rd);
        check_eq(what, rd, '0);
    endtask

    task automatic read_result(input prod_t p);
        wb_data_t rd;
        int       polls;
        rd = '0;
        polls = 0;
        // Poll until the valid flag shows up
        while (!rd[2*`CLMUL_OPND_W] && polls < POLL_MAX) begin
            read_reg(`CLMUL_ADDR_RSLT, rd);
            polls++;
        end
        if (rd[2*`CLMUL_OPND_W]) begin
            check_eq("result read", rd, wb_data_t'({1'b1, p}));
        end else begin
            $display("No valid result after %0d reads (time %0t ns)", polls, $time);
            timeouts++;
        end
    endtask

    initial begin
        int         fd;
        int         nf;
        string      line;
        logic [7:0] cmd;
        opnd_t      a;
        opnd_t      b;
        prod_t      p;
        clk      = 1'b0;
        rst_n    = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        void'($urandom(32'hc0310004));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("dv/clmul_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open stimulus file dv/clmul_stim.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                nf = $sscanf(line, "%c %h %h %h", cmd, a, b, p);
                if (nf != 4) begin
                    $display("Malformed stimulus line: %s", line);
                    errors++;
                    continue;
                end
                if (cmd == "W" || cmd == "B" || cmd == "R") begin
                    check_eq("stimulus product", wb_data_t'(p), wb_data_t'(clmul_ref(a, b)));
                end
                // Random idle gap between bus cycles
                repeat ($urandom % 4) @(negedge clk);
                case (cmd)
                    "W": write_op(`CLMUL_ADDR_OPND, a, b);
                    "B": write_stalled(a, b);
                    "R": read_result(p);
                    "E": read_expect_zero(`CLMUL_ADDR_RSLT, "empty result read");
                    "U": write_op(ADDR_UNMAPPED_W, a, b);
                    "N": read_expect_zero(ADDR_UNMAPPED_R, "unmapped read");
                    default: begin
                        $display("Unknown stimulus command %c", cmd);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/clmul_stim.txt
# cmd a b product, all hex; W write, B write that must stall, R read result
# E read expecting empty, U write to unmapped address, N read of unmapped address
E 00 00 0000
W ff ff 5555
R ff ff 5555
W 5a 00 0000
R 5a 00 0000
W 00 c3 0000
R 00 c3 0000
W 12 34 0328
W 87 65 33bb
W 0f f0 0550
W a5 5a 2772
R 12 34 0328
R 87 65 33bb
R 0f f0 0550
R a5 5a 2772
E 00 00 0000
W 01 01 0001
W 02 81 0102
W ff 01 00ff
W 11 11 0101
W 80 80 4000
B 0d 0b 007f
R 01 01 0001
W 0d 0b 007f
R 02 81 0102
R ff 01 00ff
R 11 11 0101
R 80 80 4000
R 0d 0b 007f
E 00 00 0000
W 21 43 0823
U 99 77 0000
N 00 00 0000
R 21 43 0823
E 00 00 0000

// File: all.f
+incdir+logic
logic/clmul_pkg.sv
logic/clmul_lane.sv
logic/clmul_dispatch.sv
logic/clmul_collect.sv
logic/clmul_wb_slave.sv
logic/clmul_top.sv
dv/clmul_chk.sv
dv/clmul_tb.sv

// File: Makefile
# Verilator simulation of the carry-less multiply accelerator

VERILATOR ?= verilator
TOP       ?= clmul_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
